//--- shift_pkg.sv
// ----------------------------------------------------------
// Shared types for the shift issue subsystem.
// Holds the data widths, the shift opcode encoding and the
// opcode field helpers. Modules import it in their header.
// ----------------------------------------------------------

package shift_pkg;

	typedef logic [63:0] xlen_t;    // One architectural register value.
	typedef logic [4:0]  reg_idx_t; // Architectural register number.
	typedef logic [5:0]  shamt_t;   // Shift amount or immediate.

	// Bit 0 marks the W forms, bit 1 the register forms, bits 3:2 the kind.
	typedef enum logic [3:0] {
		OP_SLLI  = 4'd0,
		OP_SLLIW = 4'd1,
		OP_SLL   = 4'd2,
		OP_SLLW  = 4'd3,
		OP_SRLI  = 4'd4,
		OP_SRLIW = 4'd5,
		OP_SRL   = 4'd6,
		OP_SRLW  = 4'd7,
		OP_SRAI  = 4'd8,
		OP_SRAIW = 4'd9,
		OP_SRA   = 4'd10,
		OP_SRAW  = 4'd11
	} shift_op_t;

	typedef enum logic [1:0] {
		KIND_LEFT        = 2'd0,
		KIND_RIGHT_LOGIC = 2'd1,
		KIND_RIGHT_ARITH = 2'd2
	} shift_kind_t;

	function automatic logic op_is_imm(shift_op_t op);
		return ~op[1]; // Immediate forms have bit 1 clear.
	endfunction

	function automatic logic op_is_word(shift_op_t op);
		return op[0];
	endfunction

	function automatic shift_kind_t op_kind(shift_op_t op);
		case (op[3:2])
			2'd0:    return KIND_LEFT;
			2'd1:    return KIND_RIGHT_LOGIC;
			default: return KIND_RIGHT_ARITH;
		endcase
	endfunction

endpackage

//--- shift_slot_if.sv
// ----------------------------------------------------------
// Link for one issue buffer entry. The buffer publishes the
// entry, the slot answers with readiness and operands, and
// the issue stage reads both and returns the pop strobe.
// ----------------------------------------------------------

`timescale 1ns/1ps

interface shift_slot_if import shift_pkg::*; ();

	logic      valid;
	shift_op_t op;
	reg_idx_t  rd;
	reg_idx_t  rs1;
	reg_idx_t  rs2;
	shamt_t    imm;

	logic      ready;
	xlen_t     op1;
	xlen_t     op2;

	logic      pop;

	modport buffer (output valid, op, rd, rs1, rs2, imm, input pop);

	modport slot (input valid, op, rs1, rs2, imm, output ready, op1, op2);

	modport issue (input ready, op, rd, op1, op2, output pop);

endinterface

//--- shift_regfile.sv
// ----------------------------------------------------------
// Architectural register file with one busy bit per register.
// An init port loads values from outside, the write-back port
// retires results. All values and busy bits are visible at
// once so every slot can read its own sources.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_regfile import shift_pkg::*; (
	input  logic              CLK,
	input  logic              reset,
	input  logic              init_we,
	input  reg_idx_t          init_addr,
	input  xlen_t             init_data,
	input  logic              set_busy,
	input  reg_idx_t          set_busy_idx,
	input  logic              wb_valid,
	input  reg_idx_t          wb_rd,
	input  xlen_t             wb_data,
	output xlen_t [31:0]      regs,
	output logic  [31:0]      busy
);

	xlen_t [31:0] mem;
	logic  [31:0] busy_q;

	always_ff @(posedge CLK) begin
		if (reset) begin
			mem <= '0;
		end else begin
			if (init_we && init_addr != '0) begin
				mem[init_addr] <= init_data;
			end
			if (wb_valid && wb_rd != '0) begin
				mem[wb_rd] <= wb_data;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy_q <= '0;
		end else begin
			if (wb_valid) begin
				busy_q[wb_rd] <= 1'b0;
			end
			if (set_busy) begin
				busy_q[set_busy_idx] <= 1'b1; // A new dispatch overrides the clear.
			end
		end
	end

	assign regs = {mem[31:1], 64'd0};         // x0 always reads zero.
	assign busy = {busy_q[31:1], 1'b0};
endmodule

//--- shift_buffer.sv
// ----------------------------------------------------------
// Issue buffer of DP entries. An accepted dispatch fills the
// lowest free entry and marks its destination busy. An entry
// is freed on its pop from the issue stage.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_buffer import shift_pkg::*; #(
	parameter int DP = 4
) (
	input  logic        CLK,
	input  logic        reset,
	input  logic        dispatch_valid,
	input  shift_op_t   dispatch_op,
	input  reg_idx_t    dispatch_rd,
	input  reg_idx_t    dispatch_rs1,
	input  reg_idx_t    dispatch_rs2,
	input  shamt_t      dispatch_imm,
	input  logic [31:0] busy,
	output logic        dispatch_stall,
	output logic        set_busy,
	output reg_idx_t    set_busy_idx,
	shift_slot_if.buffer slots [DP]
);

	localparam int IW = $clog2(DP);

	logic [DP-1:0] ent_valid;
	shift_op_t     ent_op  [DP];
	reg_idx_t      ent_rd  [DP];
	reg_idx_t      ent_rs1 [DP];
	reg_idx_t      ent_rs2 [DP];
	shamt_t        ent_imm [DP];

	logic [DP-1:0] pop_v;
	logic [DP-1:0] war_hit;
	logic [IW-1:0] free_idx;
	logic          accept;

	for (genvar i = 0; i < DP; i++) begin : g_entry
		assign slots[i].valid = ent_valid[i];
		assign slots[i].op    = ent_op[i];
		assign slots[i].rd    = ent_rd[i];
		assign slots[i].rs1   = ent_rs1[i];
		assign slots[i].rs2   = ent_rs2[i];
		assign slots[i].imm   = ent_imm[i];
		assign pop_v[i]       = slots[i].pop;
		// A waiting entry still has to read the register this dispatch would write.
		assign war_hit[i] = ent_valid[i] && dispatch_rd != '0 &&
			(ent_rs1[i] == dispatch_rd ||
			(!op_is_imm(ent_op[i]) && ent_rs2[i] == dispatch_rd));
	end

	always_comb begin
		free_idx = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (!ent_valid[i]) free_idx = IW'(i); // Lowest free entry wins.
		end
	end

	assign dispatch_stall = (&ent_valid) | busy[dispatch_rd] | (|war_hit);
	assign accept         = dispatch_valid & ~dispatch_stall;
	assign set_busy       = accept;
	assign set_busy_idx   = dispatch_rd;

	always_ff @(posedge CLK) begin
		if (reset) begin
			ent_valid <= '0;
		end else begin
			ent_valid <= (ent_valid & ~pop_v) | ({{(DP-1){1'b0}}, accept} << free_idx);
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			ent_op[free_idx]  <= dispatch_op;
			ent_rd[free_idx]  <= dispatch_rd;
			ent_rs1[free_idx] <= dispatch_rs1;
			ent_rs2[free_idx] <= dispatch_rs2;
			ent_imm[free_idx] <= dispatch_imm;
		end
	end
endmodule

//--- shift_slot.sv
// ----------------------------------------------------------
// Readiness check and operand selection for one buffer entry.
// The top places one instance per entry. Immediate forms wait
// on rs1 only, register forms on both sources.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_slot import shift_pkg::*; (
	input  xlen_t [31:0] regs,
	input  logic  [31:0] busy,
	shift_slot_if.slot   slot
);

	logic  is_imm;
	logic  rs1_ok;
	logic  rs2_ok;
	xlen_t src1;
	xlen_t src2;

	assign is_imm = op_is_imm(slot.op);
	assign src1   = regs[slot.rs1];
	assign src2   = regs[slot.rs2];

	assign rs1_ok = ~busy[slot.rs1];
	assign rs2_ok = is_imm | ~busy[slot.rs2]; // No second source on immediate forms.

	assign slot.ready = slot.valid & rs1_ok & rs2_ok;

	//------------------------------------------------------------
	// Operands
	//------------------------------------------------------------

	assign slot.op1 = src1;

	// Only six amount bits matter. The W forms drop bit 5 in the execute stage.
	assign slot.op2 = is_imm ? {58'd0, slot.imm} : {58'd0, src2[5:0]};
endmodule

//--- shift_issue.sv
// ----------------------------------------------------------
// Issue select. Picks the lowest-index ready slot each cycle,
// pops it from the buffer and registers its execute
// parameters. The execute stage never stalls.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_issue import shift_pkg::*; #(
	parameter int DP = 4
) (
	input  logic        CLK,
	input  logic        reset,
	shift_slot_if.issue slots [DP],
	output logic        exe_valid,
	output shift_op_t   exe_op,
	output reg_idx_t    exe_rd,
	output xlen_t       exe_op1,
	output xlen_t       exe_op2
);

	localparam int IW = $clog2(DP);

	logic [DP-1:0] ready_v;
	shift_op_t     op_v  [DP];
	reg_idx_t      rd_v  [DP];
	xlen_t         op1_v [DP];
	xlen_t         op2_v [DP];
	logic [IW-1:0] sel;
	logic          any_ready;

	for (genvar i = 0; i < DP; i++) begin : g_slot
		assign ready_v[i] = slots[i].ready;
		assign op_v[i]    = slots[i].op;
		assign rd_v[i]    = slots[i].rd;
		assign op1_v[i]   = slots[i].op1;
		assign op2_v[i]   = slots[i].op2;
		assign slots[i].pop = any_ready && sel == IW'(i);
	end

	always_comb begin
		sel = '0;
		for (int i = DP - 1; i >= 0; i--) begin
			if (ready_v[i]) sel = IW'(i);
		end
	end

	assign any_ready = |ready_v;

	always_ff @(posedge CLK) begin
		if (reset) begin
			exe_valid <= 1'b0;
		end else begin
			exe_valid <= any_ready; // One pop per cycle at most.
		end
	end

	always_ff @(posedge CLK) begin
		exe_op  <= op_v[sel];
		exe_rd  <= rd_v[sel];
		exe_op1 <= op1_v[sel];
		exe_op2 <= op2_v[sel];
	end
endmodule

//--- shift_exec.sv
// ----------------------------------------------------------
// Shift execute stage. Handles SLL, SRL and SRA in the 64-bit
// and the 32-bit W forms and registers the write-back.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_exec import shift_pkg::*; (
	input  logic      CLK,
	input  logic      reset,
	input  logic      exe_valid,
	input  shift_op_t exe_op,
	input  reg_idx_t  exe_rd,
	input  xlen_t     exe_op1,
	input  xlen_t     exe_op2,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xlen_t     wb_data
);

	logic [31:0] w_src;
	logic [31:0] res32;
	xlen_t       res64;
	xlen_t       result;

	assign w_src = exe_op1[31:0];

	always_comb begin
		case (op_kind(exe_op))
			KIND_LEFT: begin
				res64 = exe_op1 << exe_op2[5:0];
				res32 = w_src << exe_op2[4:0];
			end
			KIND_RIGHT_LOGIC: begin
				res64 = exe_op1 >> exe_op2[5:0];
				res32 = w_src >> exe_op2[4:0];
			end
			default: begin
				res64 = $signed(exe_op1) >>> exe_op2[5:0];
				res32 = $signed(w_src) >>> exe_op2[4:0];
			end
		endcase
		result = op_is_word(exe_op) ? {{32{res32[31]}}, res32} : res64; // W result sign-extends bit 31.
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_valid;
		end
	end

	always_ff @(posedge CLK) begin
		wb_rd   <= exe_rd;
		wb_data <= result;
	end
endmodule

//--- shift_top.sv
// ----------------------------------------------------------
// Shift issue subsystem top. Connects the register file, the
// issue buffer, one slot per buffer entry, the issue stage and
// the shifter. DP sets the buffer depth for all blocks.
// ----------------------------------------------------------

`timescale 1ns/1ps

module shift_top import shift_pkg::*; #(
	parameter int DP = 4
) (
	input  logic      CLK,
	input  logic      reset,
	input  logic      init_we,
	input  reg_idx_t  init_addr,
	input  xlen_t     init_data,
	input  logic      dispatch_valid,
	input  shift_op_t dispatch_op,
	input  reg_idx_t  dispatch_rd,
	input  reg_idx_t  dispatch_rs1,
	input  reg_idx_t  dispatch_rs2,
	input  shamt_t    dispatch_imm,
	output logic      dispatch_stall,
	output logic      wb_valid,
	output reg_idx_t  wb_rd,
	output xlen_t     wb_data
);

	xlen_t [31:0] regs;
	logic  [31:0] busy;
	logic         set_busy;
	reg_idx_t     set_busy_idx;
	logic         exe_valid;
	shift_op_t    exe_op;
	reg_idx_t     exe_rd;
	xlen_t        exe_op1;
	xlen_t        exe_op2;

	shift_slot_if slot_bus [DP] ();

	shift_regfile u_regfile (
		.CLK, .reset, .init_we, .init_addr, .init_data,
		.set_busy, .set_busy_idx, .wb_valid, .wb_rd, .wb_data,
		.regs, .busy
	);

	shift_buffer #(.DP(DP)) u_buffer (
		.CLK, .reset, .dispatch_valid, .dispatch_op, .dispatch_rd,
		.dispatch_rs1, .dispatch_rs2, .dispatch_imm, .busy,
		.dispatch_stall, .set_busy, .set_busy_idx, .slots(slot_bus)
	);

	for (genvar i = 0; i < DP; i++) begin : g_slot
		shift_slot u_slot (.regs, .busy, .slot(slot_bus[i]));
	end

	shift_issue #(.DP(DP)) u_issue (
		.CLK, .reset, .slots(slot_bus),
		.exe_valid, .exe_op, .exe_rd, .exe_op1, .exe_op2
	);

	shift_exec u_exec (
		.CLK, .reset, .exe_valid, .exe_op, .exe_rd, .exe_op1, .exe_op2,
		.wb_valid, .wb_rd, .wb_data
	);
endmodule

//--- tb_shift_top.sv
// ----------------------------------------------------------
// Random testbench for the shift issue subsystem. Drives
// dispatches into the DUT on the falling edge, keeps a
// sequential model of the register file and checks every
// write-back against it.
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_shift_top import shift_pkg::*; ();

	localparam int DP      = 4;
	localparam int N_CHAIN = 40;
	localparam int N_INSTR = 12 + N_CHAIN + 3 + (DP + 1) + 4 + 1;
	localparam int LIMIT   = 40 * N_INSTR + 500;

	logic      CLK;
	logic      reset;
	logic      init_we;
	reg_idx_t  init_addr;
	xlen_t     init_data;
	logic      dispatch_valid;
	shift_op_t dispatch_op;
	reg_idx_t  dispatch_rd;
	reg_idx_t  dispatch_rs1;
	reg_idx_t  dispatch_rs2;
	shamt_t    dispatch_imm;
	logic      dispatch_stall;
	logic      wb_valid;
	reg_idx_t  wb_rd;
	xlen_t     wb_data;

	xlen_t    model_regs [32];
	reg_idx_t pend_rd [$];   // Outstanding results in dispatch order.
	xlen_t    pend_val [$];
	int       errors;
	int       checks;
	int       tests;
	int       failed_tests;
	int       n_acc;
	int       n_wb;
	int       cycles;

	shift_top #(.DP(DP)) dut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ISA shift rule, applied one instruction at a time.
	function automatic xlen_t ref_shift(shift_op_t op, xlen_t a, xlen_t b, shamt_t imm);
		logic        imm_form;
		logic [5:0]  amt;
		logic [31:0] w;
		xlen_t       r;
		imm_form = op inside {OP_SLLI, OP_SLLIW, OP_SRLI, OP_SRLIW, OP_SRAI, OP_SRAIW};
		amt = imm_form ? imm : b[5:0];
		r = '0;
		w = '0;
		case (op)
			OP_SLLI, OP_SLL:   r = a << amt;
			OP_SRLI, OP_SRL:   r = a >> amt;
			OP_SRAI, OP_SRA:   r = $signed(a) >>> amt;
			OP_SLLIW, OP_SLLW: w = a[31:0] << amt[4:0];
			OP_SRLIW, OP_SRLW: w = a[31:0] >> amt[4:0];
			default:           w = $signed(a[31:0]) >>> amt[4:0];
		endcase
		if (op inside {OP_SLLIW, OP_SLLW, OP_SRLIW, OP_SRLW, OP_SRAIW, OP_SRAW})
			r = {{32{w[31]}}, w}; // W results sign-extend bit 31.
		return r;
	endfunction

	function automatic shift_op_t rand_op();
		return shift_op_t'(4'($urandom_range(0, 11)));
	endfunction

	// An entry that reads its own destination would wait on its own busy bit.
	function automatic reg_idx_t free_rd(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		reg_idx_t d;
		d = rd;
		while (d != '0 && (d == rs1 || d == rs2))
			d = d + 5'd1;
		return d;
	endfunction

	// Called at a falling edge, returns at the next one.
	task automatic send_once(input shift_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
			input reg_idx_t rs2, input shamt_t imm, output logic acc);
		xlen_t val;
		dispatch_valid = 1'b1;
		dispatch_op    = op;
		dispatch_rd    = rd;
		dispatch_rs1   = rs1;
		dispatch_rs2   = rs2;
		dispatch_imm   = imm;
		#1;
		acc = ~dispatch_stall;
		if (acc) begin
			val = ref_shift(op, model_regs[rs1], model_regs[rs2], imm);
			pend_rd.push_back(rd);
			pend_val.push_back(val);
			n_acc++;
			if (rd != '0)
				model_regs[rd] = val;
		end
		@(negedge CLK);
		dispatch_valid = 1'b0;
	endtask

	task automatic send(input shift_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
			input reg_idx_t rs2, input shamt_t imm);
		logic acc;
		acc = 1'b0;
		while (!acc)
			send_once(op, rd, rs1, rs2, imm, acc);
	endtask

	task automatic drain();
		while (pend_rd.size() != 0)
			@(negedge CLK);
		repeat (2) @(negedge CLK);
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", tests, name, errors - errs_before);
		end
	endtask

	task automatic retire();
		int idx;
		int alt;
		idx = -1;
		alt = -1;
		for (int i = 0; i < pend_rd.size(); i++) begin
			if (pend_rd[i] == wb_rd) begin
				if (alt < 0)
					alt = i;
				if (idx < 0 && pend_val[i] == wb_data)
					idx = i;
			end
		end
		if (idx < 0)
			idx = alt; // Writes to x0 are not ordered by busy bits.
		if (idx < 0) begin
			errors++;
			$display("error at %0t: write-back to x%0d matches no outstanding dispatch",
				$time, wb_rd);
		end else begin
			check_val("wb_data", wb_data, pend_val[idx]);
			pend_rd.delete(idx);
			pend_val.delete(idx);
		end
	endtask

	always @(negedge CLK) begin
		if (!reset && wb_valid) begin
			n_wb++;
			retire();
		end
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d write-backs outstanding",
			cycles, pend_rd.size());
		$display("Some tests failed");
		$finish;
	end

	//------------------------------------------------------------
	// Test sequence
	//------------------------------------------------------------

	initial begin
		logic     acc;
		logic     stall_seen;
		int       e0;
		int       edges;
		reg_idx_t rd;
		reg_idx_t prev_rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		xlen_t    data;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		failed_tests = 0;
		n_acc        = 0;
		n_wb         = 0;
		void'($urandom(32'h8344));
		reset          = 1'b1;
		init_we        = 1'b0;
		init_addr      = '0;
		init_data      = '0;
		dispatch_valid = 1'b0;
		dispatch_op    = OP_SLLI;
		dispatch_rd    = '0;
		dispatch_rs1   = '0;
		dispatch_rs2   = '0;
		dispatch_imm   = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (16) @(negedge CLK);
		reset = 1'b0;

		e0 = errors;
		for (int r = 0; r < 32; r++) begin
			data      = {$urandom, $urandom};
			init_we   = 1'b1;
			init_addr = 5'(r);
			init_data = data;
			if (r != 0)
				model_regs[r] = data; // Writes to x0 are ignored.
			@(negedge CLK);
		end
		init_we = 1'b0;
		for (int k = 0; k < 12; k++) begin
			rs1 = 5'($urandom);
			rs2 = 5'($urandom);
			rd  = free_rd(5'($urandom), rs1, rs2);
			send(shift_op_t'(4'(k)), rd, rs1, rs2, 6'($urandom));
		end
		drain();
		end_test("all opcodes", e0);

		e0 = errors;
		prev_rd = 5'd1;
		for (int k = 0; k < N_CHAIN; k++) begin
			rs1 = 5'($urandom);
			rs2 = 5'($urandom);
			if ($urandom_range(0, 1) == 0)
				rs1 = prev_rd;
			else
				rs2 = prev_rd;
			rd = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom);
			rd = free_rd(rd, rs1, rs2);
			send(rand_op(), rd, rs1, rs2, 6'($urandom));
			prev_rd = rd;
		end
		drain();
		end_test("dependent chains", e0);

		e0 = errors;
		send(OP_SLLI, 5'd1, 5'd2, 5'd0, 6'($urandom));
		send(OP_SRLI, 5'd3, 5'd1, 5'd0, 6'($urandom));
		send(OP_SRAI, 5'd4, 5'd3, 5'd0, 6'($urandom)); // Followers wait on this one.
		stall_seen = 1'b0;
		for (int k = 0; k <= DP; k++) begin
			send_once(rand_op(), 5'(20 + k), 5'd4, 5'd4, 6'($urandom), acc);
			if (!acc)
				stall_seen = 1'b1;
		end
		check_val("dispatch_stall", 64'(stall_seen), 64'd1);
		drain();
		end_test("full buffer", e0);

		e0 = errors;
		send(OP_SLLI, 5'd5, 5'd6, 5'd0, 6'($urandom));
		send_once(OP_SRLI, 5'd5, 5'd7, 5'd0, 6'($urandom), acc);    // x5 is still busy.
		check_val("dispatch_stall", 64'(!acc), 64'd1);
		send(OP_SLL, 5'd9, 5'd5, 5'd10, 6'($urandom));
		send_once(OP_SRAI, 5'd10, 5'd11, 5'd0, 6'($urandom), acc);  // The waiting SLL reads x10.
		check_val("dispatch_stall", 64'(!acc), 64'd1);
		drain();
		end_test("stall rules", e0);

		e0 = errors;
		send_once(OP_SLLI, 5'd12, 5'd13, 5'd0, 6'($urandom), acc);
		check_val("dispatch accepted", 64'(acc), 64'd1);
		edges = 0;
		while (!wb_valid && edges < 20) begin
			@(negedge CLK);
			edges++;
		end
		check_val("wb_valid latency", 64'(edges), 64'd2);
		drain();
		end_test("minimum latency", e0);

		e0 = errors;
		check_val("write-back count", 64'(n_wb), 64'(n_acc));
		end_test("write-back accounting", e0);

		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d dispatches",
			tests, failed_tests, checks, errors, n_acc);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end
endmodule

//--- all.f
shift_pkg.sv
shift_slot_if.sv
shift_regfile.sv
shift_buffer.sv
shift_slot.sv
shift_issue.sv
shift_exec.sv
shift_top.sv
tb_shift_top.sv

//--- Makefile
# Verilator build and run for the shift issue subsystem.

SRCS := shift_pkg.sv shift_slot_if.sv shift_regfile.sv shift_buffer.sv \
	shift_slot.sv shift_issue.sv shift_exec.sv shift_top.sv tb_shift_top.sv

.PHONY: run clean

run: obj_dir/Vtb_shift_top
	./obj_dir/Vtb_shift_top | tee sim.log
	grep -q "All tests passed" sim.log

# Rebuilt only when a source or the file list changes.
obj_dir/Vtb_shift_top: all.f $(SRCS)
	verilator --binary --timing --top-module tb_shift_top -f all.f -o Vtb_shift_top

clean:
	rm -rf obj_dir sim.log
